// ==== verilog/srio_dma_macros.svh ====
/* Fixed 32-bit AXI4-Lite data path with a 5-bit byte address.
   Changing a width here needs a matching change in the register map. */

`ifndef SRIO_DMA_MACROS_SVH
`define SRIO_DMA_MACROS_SVH

//////////////////////////////////////////////////////////////////////
// Bus widths

// Data word width
`define DMA_DATA_W       32
// Byte address width on the AXI4-Lite side
`define DMA_ADDR_W       5
// One strobe per byte lane
`define DMA_STRB_W       4
// Byte offset bits below the word index
`define DMA_ADDR_LSB     2
// Word index width, eight register slots
`define DMA_IDX_W        3

//////////////////////////////////////////////////////////////////////
// Reset values

// Default swrite size, 32 64-bit words plus the header
`define DMA_PKT_SIZE_RST 33

`endif

// ==== verilog/srio_dma_pkg.sv ====
/* Register indexes 5 to 7 are unused and carry no enum member.
   Only OKAY responses are ever returned. */

`default_nettype none

`include "srio_dma_macros.svh"

package srio_dma_pkg;

  //////////////////////////////////////////////////////////////////////
  // Register map

  // Word index of each control register
  typedef enum logic [`DMA_IDX_W-1:0] {
    REG_CMD        = 3'd0,
    REG_STATUS     = 3'd1,
    REG_NUM_PKTS   = 3'd2,
    REG_TUSER_LAST = 3'd3,
    REG_PKT_SIZE   = 3'd4
  } reg_idx_e;

  //////////////////////////////////////////////////////////////////////
  // Bus types

  // AXI response code
  typedef enum logic [1:0] {
    RESP_OKAY = 2'b00
  } axi_resp_e;

  // One data word
  typedef logic [`DMA_DATA_W-1:0] data_t;

  // Byte lane strobes
  typedef logic [`DMA_STRB_W-1:0] strb_t;

endpackage

`default_nettype wire

// ==== verilog/reg_access_if.sv ====
/* Single write port and single read port into the register block.
   Read data is combinational from rd_idx. */

`timescale 1ns/10ps
`default_nettype none

interface reg_access_if;

  // Write side, wr_en is a one-cycle pulse
  logic                     wr_en;
  srio_dma_pkg::reg_idx_e   wr_idx;
  srio_dma_pkg::data_t      wr_data;
  srio_dma_pkg::strb_t      wr_strb;

  // Read side
  srio_dma_pkg::reg_idx_e   rd_idx;
  srio_dma_pkg::data_t      rd_data;

  // Write channel engine
  modport writer (
    output wr_en,
    output wr_idx,
    output wr_data,
    output wr_strb
  );

  // Read channel engine
  modport reader (
    output rd_idx,
    input  rd_data
  );

  // Register block, decodes both indexes
  modport regs (
    input  wr_en,
    input  wr_idx,
    input  wr_data,
    input  wr_strb,
    input  rd_idx,
    output rd_data
  );

endinterface

`default_nettype wire

// ==== verilog/axil_write_channel.sv ====
/* Address and data must arrive together, one write outstanding at a time.
   No new write is taken while BVALID is high. */

`timescale 1ns/10ps
`default_nettype none

`include "srio_dma_macros.svh"

module axil_write_channel (
  input  wire logic                    S_AXI_ACLK,
  input  wire logic                    S_AXI_ARESETN,
  input  wire logic [`DMA_ADDR_W-1:0]  awaddr,
  input  wire logic                    awvalid,
  output      logic                    awready,
  input  wire srio_dma_pkg::data_t     wdata,
  input  wire srio_dma_pkg::strb_t     wstrb,
  input  wire logic                    wvalid,
  output      logic                    wready,
  output      srio_dma_pkg::axi_resp_e bresp,
  output      logic                    bvalid,
  input  wire logic                    bready,
  reg_access_if.writer                 regs
);

  // High for the single cycle in which address and data are taken
  logic accept_q;
  logic bvalid_q;
  logic start;

  //////////////////////////////////////////////////////////////////////
  // Acceptance

  // Both channels valid, idle, and no response waiting
  assign start = awvalid && wvalid && !accept_q && !bvalid_q;

  always_ff @(posedge S_AXI_ACLK)
  begin
    if (!S_AXI_ARESETN)
    begin
      accept_q <= 1'b0;
    end
    else
    begin
      accept_q <= start;
    end
  end

  // Word index and payload captured at the trigger edge
  always_ff @(posedge S_AXI_ACLK)
  begin
    if (start)
    begin
      regs.wr_idx  <= srio_dma_pkg::reg_idx_e'(awaddr[`DMA_ADDR_W-1:`DMA_ADDR_LSB]);
      regs.wr_data <= wdata;
      regs.wr_strb <= wstrb;
    end
  end

  // Register update happens at the close of the ready cycle
  assign regs.wr_en = accept_q;

  //////////////////////////////////////////////////////////////////////
  // Write response

  always_ff @(posedge S_AXI_ACLK)
  begin
    if (!S_AXI_ARESETN)
    begin
      bvalid_q <= 1'b0;
    end
    else if (accept_q)
    begin
      // Rises together with the register update
      bvalid_q <= 1'b1;
    end
    else if (bready && bvalid_q)
    begin
      bvalid_q <= 1'b0;
    end
  end

  // Both ready lines share one flop
  assign awready = accept_q;
  assign wready  = accept_q;
  assign bvalid  = bvalid_q;
  assign bresp   = srio_dma_pkg::RESP_OKAY;

endmodule

`default_nettype wire

// ==== verilog/axil_read_channel.sv ====
/* One read outstanding at a time, data returned two cycles after ARVALID.
   No new read is taken while RVALID is high. */

`timescale 1ns/10ps
`default_nettype none

`include "srio_dma_macros.svh"

module axil_read_channel (
  input  wire logic                    S_AXI_ACLK,
  input  wire logic                    S_AXI_ARESETN,
  input  wire logic [`DMA_ADDR_W-1:0]  araddr,
  input  wire logic                    arvalid,
  output      logic                    arready,
  output      srio_dma_pkg::data_t     rdata,
  output      srio_dma_pkg::axi_resp_e rresp,
  output      logic                    rvalid,
  input  wire logic                    rready,
  reg_access_if.reader                 regs
);

  logic arready_q;
  logic rvalid_q;

  //////////////////////////////////////////////////////////////////////
  // Address acceptance

  always_ff @(posedge S_AXI_ACLK)
  begin
    if (!S_AXI_ARESETN)
    begin
      arready_q <= 1'b0;
    end
    else
    begin
      // Single-cycle ready, blocked while data is pending
      arready_q <= arvalid && !arready_q && !rvalid_q;
    end
  end

  // Word index held until the next accepted read
  always_ff @(posedge S_AXI_ACLK)
  begin
    if (arvalid && !arready_q && !rvalid_q)
    begin
      regs.rd_idx <= srio_dma_pkg::reg_idx_e'(araddr[`DMA_ADDR_W-1:`DMA_ADDR_LSB]);
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Read data

  always_ff @(posedge S_AXI_ACLK)
  begin
    if (!S_AXI_ARESETN)
    begin
      rvalid_q <= 1'b0;
      rdata    <= '0;
    end
    else if (arready_q)
    begin
      // Sample the register mux at the end of the ready cycle
      rvalid_q <= 1'b1;
      rdata    <= regs.rd_data;
    end
    else if (rvalid_q && rready)
    begin
      rvalid_q <= 1'b0;
    end
  end

  assign arready = arready_q;
  assign rvalid  = rvalid_q;
  assign rresp   = srio_dma_pkg::RESP_OKAY;

endmodule

`default_nettype wire

// ==== verilog/dma_ctrl_regs.sv ====
/* Status and tuser_last are live inputs and ignore writes.
   Indexes 5 to 7 read zero and ignore writes. */

`timescale 1ns/10ps
`default_nettype none

`include "srio_dma_macros.svh"

module dma_ctrl_regs (
  input  wire logic                S_AXI_ACLK,
  input  wire logic                S_AXI_ARESETN,
  reg_access_if.regs               bus,
  input  wire srio_dma_pkg::data_t status,
  input  wire srio_dma_pkg::data_t tuser_last,
  output      srio_dma_pkg::data_t cmd,
  output      srio_dma_pkg::data_t num_pkts,
  output      srio_dma_pkg::data_t pkt_size
);

  srio_dma_pkg::data_t cmd_q;
  srio_dma_pkg::data_t num_pkts_q;
  srio_dma_pkg::data_t pkt_size_q;

  // Replace only the byte lanes whose strobe is set
  function automatic srio_dma_pkg::data_t merge_bytes(
    input srio_dma_pkg::data_t cur,
    input srio_dma_pkg::data_t wdata,
    input srio_dma_pkg::strb_t strb
  );
    srio_dma_pkg::data_t merged;
    merged = cur;
    for (int i = 0; i < `DMA_STRB_W; i++)
    begin
      if (strb[i])
      begin
        merged[i*8 +: 8] = wdata[i*8 +: 8];
      end
    end
    return merged;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Register writes

  always_ff @(posedge S_AXI_ACLK)
  begin
    if (!S_AXI_ARESETN)
    begin
      cmd_q      <= '0;
      num_pkts_q <= '0;
      pkt_size_q <= `DMA_PKT_SIZE_RST;
    end
    else if (bus.wr_en)
    begin
      case (bus.wr_idx)
        srio_dma_pkg::REG_CMD:
          cmd_q <= merge_bytes(cmd_q, bus.wr_data, bus.wr_strb);
        srio_dma_pkg::REG_NUM_PKTS:
          num_pkts_q <= merge_bytes(num_pkts_q, bus.wr_data, bus.wr_strb);
        srio_dma_pkg::REG_PKT_SIZE:
          pkt_size_q <= merge_bytes(pkt_size_q, bus.wr_data, bus.wr_strb);
        // Read-only and unused slots drop the write
        default:
        begin
        end
      endcase
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Read map

  always_comb
  begin
    case (bus.rd_idx)
      srio_dma_pkg::REG_CMD:        bus.rd_data = cmd_q;
      srio_dma_pkg::REG_STATUS:     bus.rd_data = status;
      srio_dma_pkg::REG_NUM_PKTS:   bus.rd_data = num_pkts_q;
      srio_dma_pkg::REG_TUSER_LAST: bus.rd_data = tuser_last;
      srio_dma_pkg::REG_PKT_SIZE:   bus.rd_data = pkt_size_q;
      default:                      bus.rd_data = '0;
    endcase
  end

  // Control outputs to the DMA engine
  assign cmd      = cmd_q;
  assign num_pkts = num_pkts_q;
  assign pkt_size = pkt_size_q;

endmodule

`default_nettype wire

// ==== verilog/srio_dma_ctrl_top.sv ====
/* AXI4-Lite slave, single outstanding transaction per direction, OKAY only.
   Addresses are byte addresses with word-aligned registers. */

`timescale 1ns/10ps
`default_nettype none

`include "srio_dma_macros.svh"

module srio_dma_ctrl_top (
  input  wire logic                   S_AXI_ACLK,
  input  wire logic                   S_AXI_ARESETN,
  // Write address channel
  input  wire logic [`DMA_ADDR_W-1:0] S_AXI_AWADDR,
  input  wire logic                   S_AXI_AWVALID,
  output      logic                   S_AXI_AWREADY,
  // Write data channel
  input  wire logic [`DMA_DATA_W-1:0] S_AXI_WDATA,
  input  wire logic [`DMA_STRB_W-1:0] S_AXI_WSTRB,
  input  wire logic                   S_AXI_WVALID,
  output      logic                   S_AXI_WREADY,
  // Write response channel
  output      logic [1:0]             S_AXI_BRESP,
  output      logic                   S_AXI_BVALID,
  input  wire logic                   S_AXI_BREADY,
  // Read address channel
  input  wire logic [`DMA_ADDR_W-1:0] S_AXI_ARADDR,
  input  wire logic                   S_AXI_ARVALID,
  output      logic                   S_AXI_ARREADY,
  // Read data channel
  output      logic [`DMA_DATA_W-1:0] S_AXI_RDATA,
  output      logic [1:0]             S_AXI_RRESP,
  output      logic                   S_AXI_RVALID,
  input  wire logic                   S_AXI_RREADY,
  // DMA side
  input  wire logic [`DMA_DATA_W-1:0] status,
  input  wire logic [`DMA_DATA_W-1:0] tuser_last,
  output      logic [`DMA_DATA_W-1:0] cmd,
  output      logic [`DMA_DATA_W-1:0] num_pkts,
  output      logic [`DMA_DATA_W-1:0] pkt_size
);

  // Channel engines to register block
  reg_access_if reg_bus ();

  axil_write_channel u_wr_chan (
    .S_AXI_ACLK    (S_AXI_ACLK),
    .S_AXI_ARESETN (S_AXI_ARESETN),
    .awaddr        (S_AXI_AWADDR),
    .awvalid       (S_AXI_AWVALID),
    .awready       (S_AXI_AWREADY),
    .wdata         (S_AXI_WDATA),
    .wstrb         (S_AXI_WSTRB),
    .wvalid        (S_AXI_WVALID),
    .wready        (S_AXI_WREADY),
    .bresp         (S_AXI_BRESP),
    .bvalid        (S_AXI_BVALID),
    .bready        (S_AXI_BREADY),
    .regs          (reg_bus.writer)
  );

  axil_read_channel u_rd_chan (
    .S_AXI_ACLK    (S_AXI_ACLK),
    .S_AXI_ARESETN (S_AXI_ARESETN),
    .araddr        (S_AXI_ARADDR),
    .arvalid       (S_AXI_ARVALID),
    .arready       (S_AXI_ARREADY),
    .rdata         (S_AXI_RDATA),
    .rresp         (S_AXI_RRESP),
    .rvalid        (S_AXI_RVALID),
    .rready        (S_AXI_RREADY),
    .regs          (reg_bus.reader)
  );

  // Only block that decodes register indexes
  dma_ctrl_regs u_regs (
    .S_AXI_ACLK    (S_AXI_ACLK),
    .S_AXI_ARESETN (S_AXI_ARESETN),
    .bus           (reg_bus.regs),
    .status        (status),
    .tuser_last    (tuser_last),
    .cmd           (cmd),
    .num_pkts      (num_pkts),
    .pkt_size      (pkt_size)
  );

endmodule

`default_nettype wire

// ==== dv/tb_clock_gen.sv ====
/* Free-running 10 ns clock, reset held low for the first 16 rising edges */

`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen (
  output logic S_AXI_ACLK,
  output logic S_AXI_ARESETN
);

  // Half period of 5 ns
  initial
  begin
    S_AXI_ACLK = 1'b0;
    forever #5 S_AXI_ACLK = ~S_AXI_ACLK;
  end

  // Release on a rising edge, like any other synchronous input
  initial
  begin
    S_AXI_ARESETN = 1'b0;
    repeat (16) @(posedge S_AXI_ACLK);
    S_AXI_ARESETN <= 1'b1;
  end

endmodule

`default_nettype wire

// ==== dv/srio_dma_ctrl_tb.sv ====
/* Single-master AXI4-Lite stimulus with one transaction at a time per direction.
   Concurrent assertions check the DUT against a shadow model of the register map. */

`timescale 1ns/10ps
`default_nettype none

`include "srio_dma_macros.svh"

module srio_dma_ctrl_tb;

  // About 60 transactions of at most 25 cycles each fit well inside this limit
  localparam int TIMEOUT_CYCLES = 4000;

  logic                   S_AXI_ACLK;
  logic                   S_AXI_ARESETN;
  logic [`DMA_ADDR_W-1:0] S_AXI_AWADDR;
  logic                   S_AXI_AWVALID;
  logic                   S_AXI_AWREADY;
  logic [`DMA_DATA_W-1:0] S_AXI_WDATA;
  logic [`DMA_STRB_W-1:0] S_AXI_WSTRB;
  logic                   S_AXI_WVALID;
  logic                   S_AXI_WREADY;
  logic [1:0]             S_AXI_BRESP;
  logic                   S_AXI_BVALID;
  logic                   S_AXI_BREADY;
  logic [`DMA_ADDR_W-1:0] S_AXI_ARADDR;
  logic                   S_AXI_ARVALID;
  logic                   S_AXI_ARREADY;
  logic [`DMA_DATA_W-1:0] S_AXI_RDATA;
  logic [1:0]             S_AXI_RRESP;
  logic                   S_AXI_RVALID;
  logic                   S_AXI_RREADY;
  logic [`DMA_DATA_W-1:0] status;
  logic [`DMA_DATA_W-1:0] tuser_last;
  logic [`DMA_DATA_W-1:0] cmd;
  logic [`DMA_DATA_W-1:0] num_pkts;
  logic [`DMA_DATA_W-1:0] pkt_size;

  // Shadow model of the writable registers and the expected read word
  srio_dma_pkg::data_t exp_cmd;
  srio_dma_pkg::data_t exp_num_pkts;
  srio_dma_pkg::data_t exp_pkt_size;
  srio_dma_pkg::data_t exp_rdata;

  integer seed;
  int     cycle_count;
  logic   wr_trigger;
  logic   rd_trigger;

  tb_clock_gen clk_gen (
    .S_AXI_ACLK    (S_AXI_ACLK),
    .S_AXI_ARESETN (S_AXI_ARESETN)
  );

  srio_dma_ctrl_top dut0 (.*);

  //////////////////////////////////////////////////////////////////////
  // Failure reporting

  task automatic abort_run();
    $display("TESTBENCH FAILED");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] want);
    $display("FAIL %s: got 0x%08h, expected 0x%08h", name, got, want);
    abort_run();
  endtask

  task automatic report_error(input string what);
    $display("ERROR: %s", what);
    abort_run();
  endtask

  // Run limit
  always @(posedge S_AXI_ACLK)
  begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES)
    begin
      report_error("timeout, the tests did not finish within the cycle limit");
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Assertions

  // Request conditions as the bus rules define them
  assign wr_trigger = S_AXI_AWVALID && S_AXI_WVALID && !S_AXI_AWREADY && !S_AXI_BVALID;
  assign rd_trigger = S_AXI_ARVALID && !S_AXI_ARREADY && !S_AXI_RVALID;

  a_reset_idle: assert property (@(posedge S_AXI_ACLK) $rose(S_AXI_ARESETN) |->
      !S_AXI_AWREADY && !S_AXI_WREADY && !S_AXI_BVALID && !S_AXI_ARREADY &&
      !S_AXI_RVALID && S_AXI_RDATA == 32'h0)
    else report_error("handshake outputs or RDATA not idle after reset");

  // Write channel
  a_wr_accept: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
      wr_trigger |=> S_AXI_AWREADY && S_AXI_WREADY)
    else report_error("AWREADY and WREADY did not rise one cycle after a write request");
  a_wr_single: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
      (S_AXI_AWREADY || S_AXI_WREADY) |->
      $past(wr_trigger) && S_AXI_AWREADY && S_AXI_WREADY)
    else report_error("AWREADY or WREADY high without a write request the cycle before");
  a_bvalid_rise: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
      S_AXI_AWREADY |=> S_AXI_BVALID)
    else report_error("BVALID did not follow the write ready cycle");
  a_bresp: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
      S_AXI_BVALID |-> S_AXI_BRESP == 2'b00)
    else report_mismatch("S_AXI_BRESP", 32'(S_AXI_BRESP), 32'h0);
  a_bvalid_hold: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
      S_AXI_BVALID && !S_AXI_BREADY |=> S_AXI_BVALID)
    else report_error("BVALID dropped before BREADY was seen");
  a_bvalid_block: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
      S_AXI_BVALID |=> !S_AXI_AWREADY)
    else report_error("a new write was accepted while a write response was pending");

  // Register outputs carry the new value once BVALID is high
  a_cmd: assert property (@(posedge S_AXI_ACLK)
      (S_AXI_BVALID || $rose(S_AXI_ARESETN)) |-> cmd == exp_cmd)
    else report_mismatch("cmd", cmd, exp_cmd);
  a_num_pkts: assert property (@(posedge S_AXI_ACLK)
      (S_AXI_BVALID || $rose(S_AXI_ARESETN)) |-> num_pkts == exp_num_pkts)
    else report_mismatch("num_pkts", num_pkts, exp_num_pkts);
  a_pkt_size: assert property (@(posedge S_AXI_ACLK)
      (S_AXI_BVALID || $rose(S_AXI_ARESETN)) |-> pkt_size == exp_pkt_size)
    else report_mismatch("pkt_size", pkt_size, exp_pkt_size);
  a_outputs_stable: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
      !S_AXI_AWREADY |=> $stable(cmd) && $stable(num_pkts) && $stable(pkt_size))
    else report_error("a control output changed outside a write ready cycle");

  // Read channel
  a_rd_accept: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
      rd_trigger |=> S_AXI_ARREADY)
    else report_error("ARREADY did not rise one cycle after ARVALID");
  a_rd_single: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
      S_AXI_ARREADY |-> $past(rd_trigger))
    else report_error("ARREADY high without a read request the cycle before");
  a_rvalid_rise: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
      S_AXI_ARREADY |=> S_AXI_RVALID)
    else report_error("RVALID did not follow the read ready cycle");
  a_rresp: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
      S_AXI_RVALID |-> S_AXI_RRESP == 2'b00)
    else report_mismatch("S_AXI_RRESP", 32'(S_AXI_RRESP), 32'h0);
  a_rdata: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
      S_AXI_RVALID |-> S_AXI_RDATA == exp_rdata)
    else report_mismatch("S_AXI_RDATA", S_AXI_RDATA, exp_rdata);
  a_rvalid_hold: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
      S_AXI_RVALID && !S_AXI_RREADY |=> S_AXI_RVALID && $stable(S_AXI_RDATA))
    else report_error("RVALID or RDATA changed while RREADY was low");
  a_rvalid_block: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
      S_AXI_RVALID |=> !S_AXI_ARREADY)
    else report_error("a new read was accepted while read data was pending");

  //////////////////////////////////////////////////////////////////////
  // Shadow model

  // Byte lane enable expanded to a bit mask
  function automatic srio_dma_pkg::data_t lane_mask(input srio_dma_pkg::strb_t strb);
    srio_dma_pkg::data_t mask;
    for (int b = 0; b < `DMA_STRB_W; b++)
    begin
      mask[b*8 +: 8] = {8{strb[b]}};
    end
    return mask;
  endfunction

  // Only indexes 0, 2 and 4 hold state
  task automatic update_shadow(input logic [2:0] idx, input srio_dma_pkg::data_t data,
                               input srio_dma_pkg::strb_t strb);
    srio_dma_pkg::data_t mask;
    mask = lane_mask(strb);
    case (idx)
      3'd0: exp_cmd <= (exp_cmd & ~mask) | (data & mask);
      3'd2: exp_num_pkts <= (exp_num_pkts & ~mask) | (data & mask);
      3'd4: exp_pkt_size <= (exp_pkt_size & ~mask) | (data & mask);
      default:
      begin
      end
    endcase
  endtask

  function automatic srio_dma_pkg::data_t read_model(input logic [2:0] idx);
    case (idx)
      3'd0: return exp_cmd;
      3'd1: return status;
      3'd2: return exp_num_pkts;
      3'd3: return tuser_last;
      3'd4: return exp_pkt_size;
      default: return 32'h0;
    endcase
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Bus master

  // Write with a random BREADY stall and sometimes a second request during the stall
  task automatic axil_write(input logic [2:0] idx, input srio_dma_pkg::data_t data,
                            input srio_dma_pkg::strb_t strb);
    int   stall;
    logic extra;
    stall = $random(seed) & 7;
    extra = (($random(seed) & 1) != 0);
    update_shadow(idx, data, strb);
    S_AXI_AWADDR  <= {idx, 2'b00};
    S_AXI_AWVALID <= 1'b1;
    S_AXI_WDATA   <= data;
    S_AXI_WSTRB   <= strb;
    S_AXI_WVALID  <= 1'b1;
    @(posedge S_AXI_ACLK);
    while (!S_AXI_AWREADY) @(posedge S_AXI_ACLK);
    S_AXI_AWVALID <= 1'b0;
    S_AXI_WVALID  <= 1'b0;
    while (!S_AXI_BVALID) @(posedge S_AXI_ACLK);
    if (extra)
    begin
      S_AXI_AWADDR  <= 5'($random(seed));
      S_AXI_WDATA   <= $random(seed);
      S_AXI_AWVALID <= 1'b1;
      S_AXI_WVALID  <= 1'b1;
    end
    repeat (stall) @(posedge S_AXI_ACLK);
    // Extra request withdrawn before the response is taken
    S_AXI_AWVALID <= 1'b0;
    S_AXI_WVALID  <= 1'b0;
    S_AXI_BREADY  <= 1'b1;
    @(posedge S_AXI_ACLK);
    S_AXI_BREADY  <= 1'b0;
  endtask

  // Read with a random RREADY stall
  task automatic axil_read(input logic [2:0] idx);
    int   stall;
    logic extra;
    stall = $random(seed) & 7;
    extra = (($random(seed) & 1) != 0);
    exp_rdata     <= read_model(idx);
    S_AXI_ARADDR  <= {idx, 2'b00};
    S_AXI_ARVALID <= 1'b1;
    @(posedge S_AXI_ACLK);
    while (!S_AXI_ARREADY) @(posedge S_AXI_ACLK);
    S_AXI_ARVALID <= 1'b0;
    while (!S_AXI_RVALID) @(posedge S_AXI_ACLK);
    if (extra)
    begin
      S_AXI_ARADDR  <= 5'($random(seed));
      S_AXI_ARVALID <= 1'b1;
    end
    repeat (stall) @(posedge S_AXI_ACLK);
    S_AXI_ARVALID <= 1'b0;
    S_AXI_RREADY  <= 1'b1;
    @(posedge S_AXI_ACLK);
    S_AXI_RREADY  <= 1'b0;
  endtask

  // New live values on the DMA-side inputs
  task automatic set_dma_inputs();
    status     <= $random(seed);
    tuser_last <= $random(seed);
    @(posedge S_AXI_ACLK);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Test sequence

  initial
  begin
    logic [2:0] idx;
    seed = 17;
    S_AXI_AWADDR  <= '0;
    S_AXI_AWVALID <= 1'b0;
    S_AXI_WDATA   <= '0;
    S_AXI_WSTRB   <= '0;
    S_AXI_WVALID  <= 1'b0;
    S_AXI_BREADY  <= 1'b0;
    S_AXI_ARADDR  <= '0;
    S_AXI_ARVALID <= 1'b0;
    S_AXI_RREADY  <= 1'b0;
    status        <= 32'h0;
    tuser_last    <= 32'h0;
    exp_cmd       <= 32'h0;
    exp_num_pkts  <= 32'h0;
    exp_pkt_size  <= `DMA_PKT_SIZE_RST;
    exp_rdata     <= 32'h0;
    while (!S_AXI_ARESETN) @(posedge S_AXI_ACLK);

    // Reset values through the read path
    axil_read(3'd0);
    axil_read(3'd2);
    axil_read(3'd4);

    // Full-strobe writes with a readback of each
    for (int i = 0; i < 9; i++)
    begin
      idx = 3'((i % 3) * 2);
      axil_write(idx, $random(seed), 4'hF);
      axil_read(idx);
    end

    // Partial byte lanes
    for (int i = 0; i < 9; i++)
    begin
      idx = 3'((i % 3) * 2);
      axil_write(idx, $random(seed), srio_dma_pkg::strb_t'($random(seed)));
      axil_read(idx);
    end

    // Live inputs behind the read-only slots
    for (int i = 0; i < 2; i++)
    begin
      set_dma_inputs();
      axil_read(3'd1);
      axil_read(3'd3);
    end

    // Writes to read-only and unused slots land nowhere
    axil_write(3'd1, $random(seed), 4'hF);
    axil_write(3'd3, $random(seed), 4'hF);
    for (int i = 5; i < 8; i++)
    begin
      axil_write(3'(i), $random(seed), 4'hF);
    end
    for (int i = 5; i < 8; i++)
    begin
      axil_read(3'(i));
    end
    axil_read(3'd0);
    axil_read(3'd2);
    axil_read(3'd4);

    repeat (4) @(posedge S_AXI_ACLK);
    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== compile.f ====
+incdir+verilog
verilog/srio_dma_pkg.sv
verilog/reg_access_if.sv
verilog/axil_write_channel.sv
verilog/axil_read_channel.sv
verilog/dma_ctrl_regs.sv
verilog/srio_dma_ctrl_top.sv
dv/tb_clock_gen.sv
dv/srio_dma_ctrl_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the testbench with Verilator and run it from the project root
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/10ps \
  --top-module srio_dma_ctrl_tb -f compile.f

status=0
output=$(./obj_dir/Vsrio_dma_ctrl_tb 2>&1) || status=$?
printf '%s\n' "$output"

if [ "$status" -eq 0 ] && printf '%s\n' "$output" | grep -qx "TESTBENCH PASSED"; then
  exit 0
fi
exit 1
